//--- build.f
+incdir+.
mc_pkg.sv
req_fifo.sv
row_tracker.sv
bank_timer.sv
cmd_sched.sv
mem_ctrl_top.sv
mem_ctrl_sva.sv
mem_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the fail banner in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mem_ctrl_tb \
	-f build.f -o mem_ctrl_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/mem_ctrl_sim > sim.log 2>&1 \
	|| { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure, see sim.log"; exit 1; }
echo "simulation finished without failure"
exit 0

//--- mem_ctrl_tb.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module mem_ctrl_tb;
	import mc_pkg::*;

	localparam int N_RANDOM = 400;
	localparam int N_BURST  = 40;
	localparam int N_REQ    = 2 + N_RANDOM + N_BURST + 9;
	localparam int WATCHDOG_CYCLES = N_REQ * (`T_RP + `T_RCD + `CAS_LAT + 4) + 200;

	// one owed completion, data only used for reads
	typedef struct packed {
		logic  wr;
		data_t data;
	} exp_t;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	logic     in_request_type;
	addr_t    in_request_address;
	data_t    in_request_data;
	data_t    dq_rd;
	logic     out_busy;
	logic     write_done;
	logic     read_done;
	data_t    data_out;
	mem_bus_t mem_bus;
	logic     cs_n;
	data_t    dq_wr;

	data_t               dev_mem [2**`ADDR_W];  // device array
	data_t               shadow  [2**`ADDR_W];  // reference copy, written at accept
	logic [`N_BANKS-1:0] dev_open;              // device's own open-row table
	row_t                dev_row [`N_BANKS];
	logic [`CAS_LAT:0]   dev_rd_vld;            // stage k = k cycles since rd
	data_t               dev_rd_data [`CAS_LAT+1];

	mc_req_t     req_q[$];    // accepted, in issue order
	exp_t        exp_q[$];    // completions still owed
	int          rd_due_q[$]; // cycle each read_done is due
	logic [31:0] seed;
	string       test_name;
	data_t       last_rd_data;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          accepted = 0;
	int          completed = 0;
	int          act_cnt = 0;
	int          pre_cnt = 0;

	mem_ctrl_top mem_ctrl_top_i (.clk, .rst_n, .in_valid, .in_request_type, .in_request_address,
		.in_request_data, .dq_rd, .out_busy, .write_done, .read_done, .data_out, .mem_bus,
		.cs_n, .dq_wr);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	function automatic logic [15:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16]; // upper half, better spread
	endfunction

	// every address bit lands in the word
	function automatic data_t fill_word(addr_t a);
		return a ^ {a[7:0], a[15:8]} ^ 16'h6b1d;
	endfunction

	// rows 0..3, all banks, cols 0..15: plenty of hits and misses
	function automatic addr_t random_addr();
		logic [15:0] r;
		r = lcg_next();
		return {4'd0, r[1:0], r[3:2], 4'd0, r[7:4]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED [%s] %s: expected %0h, actual %0h", test_name, what, exp, got);
		end
	endtask

	task automatic check_true(input string what, input bit ok);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERROR [%s] %s", test_name, what);
		end
	endtask

	task automatic check_idle();
		check_value("mem_bus.cmd", CMD_NOP, mem_bus.cmd);
		check_value("cs_n", 1, cs_n);
		check_value("write_done", 0, write_done);
		check_value("read_done", 0, read_done);
		check_value("out_busy", 0, out_busy);
	endtask

	task automatic drive_req(input logic wr, input addr_t a, input data_t d);
		@(posedge clk);
		#1;
		in_valid           = 1'b1;
		in_request_type    = wr;
		in_request_address = a;
		in_request_data    = d;
	endtask

	// hold the request until a cycle with out_busy low takes it
	task automatic send(input logic wr, input addr_t a, input data_t d);
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			drive_req(wr, a, d);
			@(negedge clk);
			taken = !out_busy;
		end
	endtask

	task automatic idle();
		@(posedge clk);
		#1 in_valid = 1'b0;
	endtask

	// wait for the owed completions, bounded
	task automatic drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || rd_due_q.size() != 0) && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		check_true("requests still outstanding after drain", exp_q.size() == 0);
	endtask

	initial begin
		for (int a = 0; a < 2**`ADDR_W; a++) begin
			dev_mem[a] = fill_word(addr_t'(a));
			shadow[a]  = fill_word(addr_t'(a));
		end
		dev_open   = '0;
		dev_rd_vld = '0;
		dq_rd      = '0;
	end

	// device model, looks at the bus once it has settled
	always @(posedge clk) begin
		mc_req_t want;
		addr_t   a;
		#1;
		for (int k = `CAS_LAT; k > 0; k--) begin
			dev_rd_vld[k]  = dev_rd_vld[k-1];
			dev_rd_data[k] = dev_rd_data[k-1];
		end
		dev_rd_vld[0] = 1'b0;
		if (mem_bus.cmd != CMD_NOP)
			check_value("cs_n on a command", 0, cs_n); // device only listens when selected
		case (mem_bus.cmd)
			CMD_ACT: begin
				dev_open[mem_bus.bank] = 1'b1;
				dev_row[mem_bus.bank]  = mem_bus.bus_addr[`ROW_W-1:0];
			end
			CMD_PRE: dev_open[mem_bus.bank] = 1'b0;
			CMD_RD, CMD_WR: begin
				a = {dev_row[mem_bus.bank], mem_bus.bank, mem_bus.bus_addr[`COL_W-1:0]};
				check_true("column command to a closed bank", dev_open[mem_bus.bank]);
				if (req_q.size() == 0) begin
					check_true("column command with no request pending", 1'b0);
				end else begin
					want = req_q.pop_front();
					check_value("column address", want.addr, a); // catches a wrong row
					check_value("column command is wr", want.wr, mem_bus.cmd == CMD_WR);
				end
				if (mem_bus.cmd == CMD_WR) begin
					dev_mem[a] = dq_wr;
				end else begin
					dev_rd_vld[0]  = 1'b1;
					dev_rd_data[0] = dev_mem[a];
				end
			end
			default: ;
		endcase
		if (dev_rd_vld[`CAS_LAT])
			dq_rd = dev_rd_data[`CAS_LAT]; // held until the next read
	end

	// monitor and reference model, mid-cycle
	always @(negedge clk) begin
		exp_t e;
		if (rst_n) begin
			cyc++;
			if (in_valid && !out_busy) begin
				req_q.push_back('{wr: in_request_type, addr: in_request_address,
					data: in_request_data});
				if (in_request_type)
					shadow[in_request_address] = in_request_data;
				exp_q.push_back('{wr: in_request_type, data: shadow[in_request_address]});
				accepted++;
			end
			if (mem_bus.cmd == CMD_ACT)
				act_cnt++;
			if (mem_bus.cmd == CMD_PRE)
				pre_cnt++;
			if (mem_bus.cmd == CMD_RD)
				rd_due_q.push_back(cyc + `CAS_LAT + 1);
			if (!read_done && rd_due_q.size() != 0)
				check_true("read_done missing at its due cycle", rd_due_q[0] != cyc);
			if (write_done || read_done) begin
				check_true("write_done and read_done together", !(write_done && read_done));
				if (exp_q.size() == 0) begin
					check_true("completion with nothing outstanding", 1'b0);
				end else begin
					e = exp_q.pop_front();
					check_value("completion is a write", e.wr, write_done);
					if (read_done) begin
						check_value("read data", e.data, data_out);
						last_rd_data = data_out;
					end
				end
				if (read_done && rd_due_q.size() == 0)
					check_true("read_done without a rd on the bus", 1'b0);
				else if (read_done)
					check_value("read_done cycle", rd_due_q.pop_front(), cyc);
				completed++;
			end
		end
	end

	initial begin
		int          acc0;
		int          done0;
		int          act0;
		int          pre0;
		logic [15:0] r;
		seed               = 32'd51;
		rst_n              = 1'b0;
		in_valid           = 1'b0;
		in_request_type    = 1'b0;
		in_request_address = '0;
		in_request_data    = '0;

		test_name = "reset";
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (i == 3)
				#1 rst_n = 1'b1;
			@(negedge clk);
			check_idle();
		end
		@(negedge clk);
		check_idle(); // first cycle out of reset

		test_name = "write_read";
		send(1'b1, 16'h1234, 16'hbeef);
		send(1'b0, 16'h1234, 16'h0000);
		idle();
		drain();
		check_value("read back", 16'hbeef, last_rd_data);

		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			r = lcg_next();
			if (r[1] && r[2])
				idle(); // occasional gap
			send(r[0], random_addr(), lcg_next());
		end
		idle();
		drain();

		test_name = "backpressure";
		acc0  = accepted;
		done0 = completed;
		for (int i = 0; i < N_BURST; i++) begin
			r = lcg_next();
			drive_req(r[0], random_addr(), lcg_next()); // every cycle, busy or not
		end
		idle();
		drain();
		check_value("completions", accepted - acc0, completed - done0);
		check_true("burst never saw out_busy", accepted - acc0 < N_BURST);

		test_name = "row_policy";
		act0 = act_cnt;
		for (int i = 0; i < 8; i++)
			send(1'b0, {6'd40, 2'd1, 8'(i)}, '0);
		idle();
		drain();
		check_value("act count, one row", 1, act_cnt - act0);
		act0 = act_cnt;
		pre0 = pre_cnt;
		send(1'b0, {6'd41, 2'd1, 8'd0}, '0); // same bank, other row
		idle();
		drain();
		check_value("pre count, row change", 1, pre_cnt - pre0);
		check_value("act count, row change", 1, act_cnt - act0);

		repeat (2) @(posedge clk);
		check_value("reads still in flight", 0, rd_due_q.size());
		$display("checks %0d, errors %0d, accepted %0d, completed %0d",
			checks, errors, accepted, completed);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not end within %0d cycles, errors %0d",
			WATCHDOG_CYCLES, errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- mem_ctrl_sva.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module mem_ctrl_sva (
	input logic             clk,
	input logic             rst_n,
	input mc_pkg::mem_bus_t mem_bus,
	input logic             cs_n,
	input logic             write_done
);
	import mc_pkg::*;

	mem_cmd_e cmd;
	bank_t    bank;
	logic     is_col;

	assign cmd    = mem_bus.cmd;
	assign bank   = mem_bus.bank;
	assign is_col = (cmd == CMD_RD) || (cmd == CMD_WR);

	// no act to this bank in the T_RCD-1 cycles before a column command
	for (genvar k = 1; k < `T_RCD; k++) begin : g_rcd
		a_rcd: assert property (@(posedge clk) disable iff (!rst_n)
			is_col |-> !($past(cmd, k) == CMD_ACT && $past(bank, k) == bank))
			else $error("rd/wr to bank %0d only %0d cycles after act", bank, k);
	end

	// pre -> act spacing
	for (genvar k = 1; k < `T_RP; k++) begin : g_rp
		a_rp: assert property (@(posedge clk) disable iff (!rst_n)
			cmd == CMD_ACT |-> !($past(cmd, k) == CMD_PRE && $past(bank, k) == bank))
			else $error("act to bank %0d only %0d cycles after pre", bank, k);
	end

	a_wr_done: assert property (@(posedge clk) disable iff (!rst_n)
		write_done |-> cmd == CMD_WR)
		else $error("write_done without a wr on the bus");

	a_nop_desel: assert property (@(posedge clk) disable iff (!rst_n)
		cmd == CMD_NOP |-> cs_n)
		else $error("cs_n low with a nop on the bus");

endmodule

bind cmd_sched mem_ctrl_sva mem_ctrl_sva_i (.clk, .rst_n, .mem_bus, .cs_n, .write_done);

//--- mem_ctrl_top.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module mem_ctrl_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic             in_request_type,
	input  mc_pkg::addr_t    in_request_address,
	input  mc_pkg::data_t    in_request_data,
	input  mc_pkg::data_t    dq_rd,
	output logic             out_busy,
	output logic             write_done,
	output logic             read_done,
	output mc_pkg::data_t    data_out,
	output mc_pkg::mem_bus_t mem_bus,
	output logic             cs_n,
	output mc_pkg::data_t    dq_wr
);
	import mc_pkg::*;

	mc_req_t    push_req;
	mc_req_t    head;
	logic       push;
	logic       pop;
	logic       head_valid;
	bank_t      head_bank;
	row_t       head_row;
	row_state_t row_state;
	logic       col_ok;
	logic       act_ok;
	mem_cmd_e   issue_cmd;
	bank_t      issue_bank;
	row_t       issue_row;

	// host side, taken only while not busy
	assign push     = in_valid && !out_busy;
	assign push_req = '{wr: in_request_type, addr: in_request_address, data: in_request_data};

	assign head_bank = head.addr[`COL_W +: `BANK_W];
	assign head_row  = head.addr[`COL_W + `BANK_W +: `ROW_W];

	req_fifo req_fifo_i (.clk, .rst_n, .push, .push_req, .pop, .head, .head_valid,
		.full(out_busy));

	// tracker and timer both look at the head request
	row_tracker row_tracker_i (.clk, .rst_n, .head_bank, .head_row, .issue_cmd,
		.issue_bank, .issue_row, .row_state);

	bank_timer bank_timer_i (.clk, .rst_n, .head_bank, .issue_cmd, .issue_bank,
		.col_ok, .act_ok);

	cmd_sched cmd_sched_i (.clk, .rst_n, .head, .head_valid, .row_state, .col_ok,
		.act_ok, .dq_rd, .pop, .issue_cmd, .issue_bank, .issue_row, .mem_bus, .cs_n,
		.dq_wr, .write_done, .read_done, .data_out);

endmodule

//--- cmd_sched.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module cmd_sched (
	input  logic               clk,
	input  logic               rst_n,
	input  mc_pkg::mc_req_t    head,
	input  logic               head_valid,
	input  mc_pkg::row_state_t row_state,
	input  logic               col_ok,
	input  logic               act_ok,
	input  mc_pkg::data_t      dq_rd,
	output logic               pop,
	output mc_pkg::mem_cmd_e   issue_cmd,
	output mc_pkg::bank_t      issue_bank,
	output mc_pkg::row_t       issue_row,
	output mc_pkg::mem_bus_t   mem_bus,
	output logic               cs_n,
	output mc_pkg::data_t      dq_wr,
	output logic               write_done,
	output logic               read_done,
	output mc_pkg::data_t      data_out
);
	import mc_pkg::*;

	sched_state_e     state;
	sched_state_e     state_d;
	sched_state_e     want;      // step the head needs now
	col_t             head_col;
	bank_t            head_bank;
	row_t             head_row;
	mem_bus_t         bus_d;
	logic [`CAS_LAT:0] rd_pipe;  // rd in flight, bit k = k cycles since rd on bus

	// address split: row | bank | col
	assign head_col  = head.addr[`COL_W-1:0];
	assign head_bank = head.addr[`COL_W +: `BANK_W];
	assign head_row  = head.addr[`COL_W + `BANK_W +: `ROW_W];

	assign issue_bank = head_bank;
	assign issue_row  = head_row;

	// idle resolves straight from the row verdict so a hit goes out at once
	always_comb begin
		want = state;
		if (state == S_IDLE) begin
			case (row_state)
				`RS_HIT:  want = S_COL;
				`RS_MISS: want = S_PRE;
				default:  want = S_ACT;
			endcase
		end
	end

	// one command per cycle
	always_comb begin
		issue_cmd = CMD_NOP;
		pop       = 1'b0;
		state_d   = state;
		if (head_valid) begin
			state_d = want; // hold the step while its timer runs
			case (want)
				S_PRE: begin
					issue_cmd = CMD_PRE;
					state_d   = S_ACT;
				end
				S_ACT: begin
					if (act_ok) begin
						issue_cmd = CMD_ACT;
						state_d   = S_COL;
					end
				end
				S_COL: begin
					// a write waits out reads in flight so completions stay in order
					if (col_ok && !(head.wr && rd_pipe != '0)) begin
						issue_cmd = head.wr ? CMD_WR : CMD_RD;
						pop       = 1'b1; // head done once its column cmd leaves
						state_d   = S_IDLE;
					end
				end
				default: state_d = S_IDLE;
			endcase
		end
	end

	// bus word for the chosen command
	always_comb begin
		bus_d.cmd  = issue_cmd;
		bus_d.bank = head_bank;
		case (issue_cmd)
			CMD_ACT:        bus_d.bus_addr = baddr_t'(head_row);
			CMD_RD, CMD_WR: bus_d.bus_addr = baddr_t'(head_col);
			default:        bus_d.bus_addr = '0; // pre and nop carry no address
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			mem_bus    <= '{cmd: CMD_NOP, bank: '0, bus_addr: '0};
			cs_n       <= 1'b1;  // deselected
			write_done <= 1'b0;
			rd_pipe    <= '0;
			read_done  <= 1'b0;
		end else begin
			state      <= state_d;
			mem_bus    <= bus_d;
			cs_n       <= (issue_cmd == CMD_NOP);
			write_done <= (issue_cmd == CMD_WR); // lines up with wr on the bus
			rd_pipe    <= {rd_pipe[`CAS_LAT-1:0], (issue_cmd == CMD_RD)};
			read_done  <= rd_pipe[`CAS_LAT];      // one after the dq_rd sample
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (issue_cmd == CMD_WR)
			dq_wr <= head.data;
		if (rd_pipe[`CAS_LAT])
			data_out <= dq_rd; // sample CAS_LAT after rd
	end

endmodule

//--- bank_timer.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module bank_timer (
	input  logic             clk,
	input  logic             rst_n,
	input  mc_pkg::bank_t    head_bank,
	input  mc_pkg::mem_cmd_e issue_cmd,
	input  mc_pkg::bank_t    issue_bank,
	output logic             col_ok,
	output logic             act_ok
);
	import mc_pkg::*;

	// counters start on the edge that puts the command on the bus,
	// so a load of T-1 lets the next command out exactly T cycles later
	localparam tmr_t RCD_LOAD = tmr_t'(`T_RCD - 1);
	localparam tmr_t RP_LOAD  = tmr_t'(`T_RP - 1);

	tmr_t rcd_cnt [`N_BANKS]; // act -> column
	tmr_t rp_cnt  [`N_BANKS]; // pre -> act

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int b = 0; b < `N_BANKS; b++) begin
				rcd_cnt[b] <= '0; // everything ready out of reset
				rp_cnt[b]  <= '0;
			end
		end else begin
			for (int b = 0; b < `N_BANKS; b++) begin
				if (issue_cmd == CMD_ACT && issue_bank == bank_t'(b))
					rcd_cnt[b] <= RCD_LOAD;
				else if (rcd_cnt[b] != '0)
					rcd_cnt[b] <= rcd_cnt[b] - 1'b1;

				if (issue_cmd == CMD_PRE && issue_bank == bank_t'(b))
					rp_cnt[b] <= RP_LOAD;
				else if (rp_cnt[b] != '0)
					rp_cnt[b] <= rp_cnt[b] - 1'b1; // saturate at zero
			end
		end
	end

	// flags for the bank the head request targets
	assign col_ok = (rcd_cnt[head_bank] == '0);
	assign act_ok = (rp_cnt[head_bank] == '0);

endmodule

//--- row_tracker.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module row_tracker (
	input  logic               clk,
	input  logic               rst_n,
	input  mc_pkg::bank_t      head_bank,
	input  mc_pkg::row_t       head_row,
	input  mc_pkg::mem_cmd_e   issue_cmd,
	input  mc_pkg::bank_t      issue_bank,
	input  mc_pkg::row_t       issue_row,
	output mc_pkg::row_state_t row_state
);
	import mc_pkg::*;

	logic [`N_BANKS-1:0] open_vld;          // bank has an active row
	row_t                open_row [`N_BANKS]; // meaningful only with open_vld

	// open / close follows the command chosen this cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			open_vld <= '0; // all banks precharged
		end else begin
			case (issue_cmd)
				CMD_ACT: open_vld[issue_bank] <= 1'b1;
				CMD_PRE: open_vld[issue_bank] <= 1'b0;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_cmd == CMD_ACT)
			open_row[issue_bank] <= issue_row;
	end

	// verdict for the head request
	always_comb begin
		if (!open_vld[head_bank])
			row_state = `RS_CLOSED;
		else if (open_row[head_bank] == head_row)
			row_state = `RS_HIT;
		else
			row_state = `RS_MISS; // other row open, needs pre
	end

endmodule

//--- req_fifo.sv
`timescale 1ns/1ns
`include "mc_consts.svh"

module req_fifo (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            push,
	input  mc_pkg::mc_req_t push_req,
	input  logic            pop,
	output mc_pkg::mc_req_t head,
	output logic            head_valid,
	output logic            full
);
	import mc_pkg::*;

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	mc_req_t          mem [`FIFO_DEPTH]; // storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_d;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full; // drop anything offered while full
	assign do_pop  = pop && head_valid;
	assign count_d = count + CNT_W'(do_push) - CNT_W'(do_pop);

	assign head       = mem[rd_ptr]; // oldest entry
	assign head_valid = (count != '0);

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
		end else begin
			if (do_push) begin
				if (wr_ptr == PTR_W'(`FIFO_DEPTH - 1))
					wr_ptr <= '0; // wrap
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == PTR_W'(`FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_d;
			full  <= (count_d == CNT_W'(`FIFO_DEPTH)); // busy level for the host
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_req;
	end

endmodule

//--- mc_pkg.sv
`include "mc_consts.svh"

package mc_pkg;

	// plain vectors for the fields that mean something
	typedef logic [`ADDR_W-1:0]     addr_t;
	typedef logic [`DATA_W-1:0]     data_t;
	typedef logic [`BANK_W-1:0]     bank_t;
	typedef logic [`ROW_W-1:0]      row_t;
	typedef logic [`COL_W-1:0]      col_t;
	typedef logic [`BUS_ADDR_W-1:0] baddr_t;
	typedef logic [`TMR_W-1:0]      tmr_t;   // per bank delay counter
	typedef logic [1:0]             row_state_t; // closed / hit / miss codes

	// command bus opcodes, nop must stay zero
	typedef enum logic [2:0] {
		CMD_NOP,
		CMD_ACT,
		CMD_PRE,
		CMD_RD,
		CMD_WR
	} mem_cmd_e;

	// scheduler phase for the head request
	typedef enum logic [1:0] {
		S_IDLE,  // pick next step from row verdict
		S_PRE,   // row miss, close bank first
		S_ACT,   // bank closed, wait act_ok
		S_COL    // row open, wait col_ok
	} sched_state_e;

	// one queued host request, 33 bits
	typedef struct packed {
		logic  wr;    // 1 = write
		addr_t addr;
		data_t data;
	} mc_req_t;

	typedef struct packed {
		mem_cmd_e cmd;
		bank_t    bank;
		baddr_t   bus_addr;  // row on act, col on rd/wr
	} mem_bus_t;

endpackage

//--- mc_consts.svh
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// host side widths
`define ADDR_W      16
`define DATA_W      16

// address split, msb first: row | bank | col
`define ROW_W       6
`define BANK_W      2
`define COL_W       8
`define N_BANKS     (1 << `BANK_W)

`define BUS_ADDR_W  14          // shared row/col field on the command bus
`define FIFO_DEPTH  4           // request queue entries

// device timing in controller clocks
`define T_RCD       3           // act -> rd/wr, same bank
`define T_RP        3           // pre -> act, same bank
`define CAS_LAT     4           // rd -> data on dq_rd
`define TMR_W       2           // wide enough for T_RCD-1 and T_RP-1

// row tracker verdict
`define RS_CLOSED   2'd0
`define RS_HIT      2'd1
`define RS_MISS     2'd2

`endif
